/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= rv_core_tb
FILELIST  ?= rv_core.f
PASS_MSG  := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

/* rtl/rv_alu.sv */
module rv_alu (
  input  rv_core_pkg::alu_op_e        op,
  input  rv_core_pkg::word_t          a,
  input  rv_core_pkg::word_t          b,
  input  rv_core_pkg::word_t          rs1_data,
  input  rv_core_pkg::word_t          rs2_data,
  input  rv_isa_pkg::funct3_branch_e  branch_cond,
  output rv_core_pkg::word_t          result,
  output logic                        branch_taken
);

  logic [4:0] shamt;
  logic       a_lt_s;
  logic       a_lt_u;
  logic       rs_eq;
  logic       rs_lt_s;
  logic       rs_lt_u;

  assign shamt  = b[4:0];  // upper bits of b ignored for shifts
  assign a_lt_s = $signed(a) < $signed(b);
  assign a_lt_u = a < b;

  // branch compares always use the raw register values
  assign rs_eq   = rs1_data == rs2_data;
  assign rs_lt_s = $signed(rs1_data) < $signed(rs2_data);
  assign rs_lt_u = rs1_data < rs2_data;

  always_comb begin
    case (op)
      rv_core_pkg::alu_add:    result = a + b;
      rv_core_pkg::alu_sub:    result = a - b;
      rv_core_pkg::alu_sll:    result = a << shamt;
      rv_core_pkg::alu_slt:    result = {{(rv_core_pkg::xlen-1){1'b0}}, a_lt_s};
      rv_core_pkg::alu_sltu:   result = {{(rv_core_pkg::xlen-1){1'b0}}, a_lt_u};
      rv_core_pkg::alu_xor:    result = a ^ b;
      rv_core_pkg::alu_srl:    result = a >> shamt;
      rv_core_pkg::alu_sra:    result = $signed(a) >>> shamt;  // sign fill
      rv_core_pkg::alu_or:     result = a | b;
      rv_core_pkg::alu_and:    result = a & b;
      rv_core_pkg::alu_pass_b: result = b;
      default:                 result = a + b;
    endcase
  end

  // condition only, the core qualifies it with is_branch
  always_comb begin
    case (branch_cond)
      rv_isa_pkg::br_beq:  branch_taken = rs_eq;
      rv_isa_pkg::br_bne:  branch_taken = !rs_eq;
      rv_isa_pkg::br_blt:  branch_taken = rs_lt_s;
      rv_isa_pkg::br_bge:  branch_taken = !rs_lt_s;
      rv_isa_pkg::br_bltu: branch_taken = rs_lt_u;
      rv_isa_pkg::br_bgeu: branch_taken = !rs_lt_u;
      default:             branch_taken = 1'b0;
    endcase
  end

endmodule

/* rtl/rv_core.sv */
module rv_core (
  input  logic                  clk,
  input  logic                  rst,
  output rv_core_pkg::word_t    pc,
  input  rv_core_pkg::word_t    insn,
  output rv_core_pkg::word_t    dmem_addr,
  input  rv_core_pkg::word_t    dmem_rdata,
  output rv_core_pkg::word_t    dmem_wdata,
  output rv_core_pkg::byte_we_t dmem_we,
  output logic                  halt
);

  rv_isa_pkg::insn_fields_t fields;
  rv_core_pkg::ctrl_t       ctrl;

  rv_core_pkg::word_t imm;
  rv_core_pkg::word_t rs1_data;
  rv_core_pkg::word_t rs2_data;
  rv_core_pkg::word_t alu_a;
  rv_core_pkg::word_t alu_b;
  rv_core_pkg::word_t alu_result;
  rv_core_pkg::word_t wb_data;
  rv_core_pkg::word_t pc_plus4;
  rv_core_pkg::word_t pc_target;  // branch and jal destination
  rv_core_pkg::word_t pc_next;

  logic branch_taken;
  logic rf_we;

  assign fields = rv_isa_pkg::insn_fields_t'(insn);

  rv_decoder i_rv_decoder (
    .insn (insn),
    .ctrl (ctrl),
    .imm  (imm)
  );

  rv_regfile i_rv_regfile (
    .clk      (clk),
    .rst      (rst),
    .we       (rf_we),
    .rd       (fields.rd),
    .rd_data  (wb_data),
    .rs1      (fields.rs1),
    .rs1_data (rs1_data),
    .rs2      (fields.rs2),
    .rs2_data (rs2_data)
  );

  assign alu_a = ctrl.src_a_pc  ? pc  : rs1_data;
  assign alu_b = ctrl.src_b_imm ? imm : rs2_data;

  rv_alu i_rv_alu (
    .op           (ctrl.alu_op),
    .a            (alu_a),
    .b            (alu_b),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .branch_cond  (ctrl.branch_cond),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

  assign halt = ctrl.is_halt;

  always_comb begin
    case (ctrl.wb_sel)
      rv_core_pkg::wb_pc_plus4: wb_data = pc_plus4;
      rv_core_pkg::wb_load:     wb_data = dmem_rdata;
      default:                  wb_data = alu_result;
    endcase
  end

  assign rf_we = ctrl.rf_we && !halt;

  // data port, address is the alu sum of rs1 and the immediate
  assign dmem_addr  = alu_result;
  assign dmem_wdata = rs2_data;
  assign dmem_we    = (ctrl.is_store && !halt) ? rv_core_pkg::store_we_word : '0;

  assign pc_plus4  = pc + rv_core_pkg::word_t'(rv_core_pkg::pc_step);
  assign pc_target = pc + imm;

  always_comb begin
    if (halt) begin
      pc_next = pc;  // park on the ecall
    end else if (ctrl.is_jal || (ctrl.is_branch && branch_taken)) begin
      pc_next = pc_target;
    end else if (ctrl.is_jalr) begin
      pc_next = {alu_result[rv_core_pkg::xlen-1:1], 1'b0};
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= rv_core_pkg::reset_pc;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

/* rtl/rv_core_pkg.sv */
package rv_core_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_addr_t;

  localparam int num_regs = 32;
  localparam int unsigned pc_step = 4;  // one word per instruction

  typedef logic [3:0] byte_we_t;
  localparam byte_we_t store_we_word = 4'b1111;

  localparam word_t reset_pc = '0;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b  // lui
  } alu_op_e;

  typedef enum logic [1:0] {
    wb_alu,
    wb_pc_plus4,  // link value of jal / jalr
    wb_load
  } wb_sel_e;

  // all-zero value is a no-op
  typedef struct packed {
    alu_op_e                    alu_op;
    logic                       src_a_pc;   // operand a is the pc
    logic                       src_b_imm;  // operand b is the immediate
    logic                       rf_we;
    wb_sel_e                    wb_sel;
    logic                       is_branch;
    rv_isa_pkg::funct3_branch_e branch_cond;
    logic                       is_jal;
    logic                       is_jalr;
    logic                       is_store;
    logic                       is_halt;
  } ctrl_t;

endpackage

/* rtl/rv_decoder.sv */
module rv_decoder (
  input  rv_core_pkg::word_t insn,
  output rv_core_pkg::ctrl_t ctrl,
  output rv_core_pkg::word_t imm
);

  rv_isa_pkg::insn_fields_t fields;

  rv_core_pkg::word_t imm_i;
  rv_core_pkg::word_t imm_s;
  rv_core_pkg::word_t imm_b;
  rv_core_pkg::word_t imm_u;
  rv_core_pkg::word_t imm_j;

  logic f7_base;
  logic f7_alt;
  logic shift_op;
  logic sr_alt;   // sra / srai
  logic ri_legal;
  logic rr_legal;

  assign fields = rv_isa_pkg::insn_fields_t'(insn);

  // immediates, sign bit is always insn[31]
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

  assign f7_base  = fields.funct7 == rv_isa_pkg::funct7_base;
  assign f7_alt   = fields.funct7 == rv_isa_pkg::funct7_alt;
  assign shift_op = fields.funct3 inside {rv_isa_pkg::f3_sll, rv_isa_pkg::f3_srl_sra};
  assign sr_alt   = f7_alt && fields.funct3 == rv_isa_pkg::f3_srl_sra;

  // immediate forms only constrain funct7 on shifts
  assign ri_legal = !shift_op || f7_base || sr_alt;
  assign rr_legal = f7_base || sr_alt || (f7_alt && fields.funct3 == rv_isa_pkg::f3_add);

  function automatic rv_core_pkg::alu_op_e alu_op_from(logic [2:0] funct3, logic alt);
    case (funct3)
      rv_isa_pkg::f3_add:     return alt ? rv_core_pkg::alu_sub : rv_core_pkg::alu_add;
      rv_isa_pkg::f3_sll:     return rv_core_pkg::alu_sll;
      rv_isa_pkg::f3_slt:     return rv_core_pkg::alu_slt;
      rv_isa_pkg::f3_sltu:    return rv_core_pkg::alu_sltu;
      rv_isa_pkg::f3_xor:     return rv_core_pkg::alu_xor;
      rv_isa_pkg::f3_srl_sra: return alt ? rv_core_pkg::alu_sra : rv_core_pkg::alu_srl;
      rv_isa_pkg::f3_or:      return rv_core_pkg::alu_or;
      rv_isa_pkg::f3_and:     return rv_core_pkg::alu_and;
      default:                return rv_core_pkg::alu_add;
    endcase
  endfunction

  always_comb begin
    ctrl = '0;
    imm  = '0;
    case (fields.opcode)
      rv_isa_pkg::op_lui: begin
        ctrl.alu_op    = rv_core_pkg::alu_pass_b;
        ctrl.src_b_imm = 1'b1;
        ctrl.rf_we     = 1'b1;
        imm            = imm_u;
      end
      rv_isa_pkg::op_auipc: begin
        ctrl.src_a_pc  = 1'b1;  // pc + upper immediate
        ctrl.src_b_imm = 1'b1;
        ctrl.rf_we     = 1'b1;
        imm            = imm_u;
      end
      rv_isa_pkg::op_jal: begin
        ctrl.is_jal = 1'b1;
        ctrl.rf_we  = 1'b1;
        ctrl.wb_sel = rv_core_pkg::wb_pc_plus4;
        imm         = imm_j;
      end
      rv_isa_pkg::op_jalr: begin
        ctrl.is_jalr   = 1'b1;
        ctrl.src_b_imm = 1'b1;  // alu forms rs1 + imm
        ctrl.rf_we     = 1'b1;
        ctrl.wb_sel    = rv_core_pkg::wb_pc_plus4;
        imm            = imm_i;
      end
      rv_isa_pkg::op_branch: begin
        imm = imm_b;
        if (fields.funct3 inside {rv_isa_pkg::br_beq, rv_isa_pkg::br_bne,
                                  rv_isa_pkg::br_blt, rv_isa_pkg::br_bge,
                                  rv_isa_pkg::br_bltu, rv_isa_pkg::br_bgeu}) begin
          ctrl.is_branch   = 1'b1;
          ctrl.branch_cond = rv_isa_pkg::funct3_branch_e'(fields.funct3);
        end
      end
      rv_isa_pkg::op_load: begin
        imm = imm_i;
        if (fields.funct3 == rv_isa_pkg::funct3_mem_word) begin
          ctrl.src_b_imm = 1'b1;
          ctrl.rf_we     = 1'b1;
          ctrl.wb_sel    = rv_core_pkg::wb_load;
        end
      end
      rv_isa_pkg::op_store: begin
        imm = imm_s;
        if (fields.funct3 == rv_isa_pkg::funct3_mem_word) begin
          ctrl.src_b_imm = 1'b1;
          ctrl.is_store  = 1'b1;
        end
      end
      rv_isa_pkg::op_reg_imm: begin
        imm = imm_i;
        if (ri_legal) begin
          ctrl.alu_op    = alu_op_from(fields.funct3, sr_alt);
          ctrl.src_b_imm = 1'b1;
          ctrl.rf_we     = 1'b1;
        end
      end
      rv_isa_pkg::op_reg_reg: begin
        if (rr_legal) begin
          ctrl.alu_op = alu_op_from(fields.funct3, f7_alt);
          ctrl.rf_we  = 1'b1;
        end
      end
      rv_isa_pkg::op_system: begin
        ctrl.is_halt = insn == rv_isa_pkg::ecall_word;  // other system ops are no-ops
      end
      default: ;
    endcase
  end

endmodule

/* rtl/rv_isa_pkg.sv */
package rv_isa_pkg;

  // major opcodes, bits [6:0] of every instruction
  typedef enum logic [6:0] {
    op_lui     = 7'b0110111,
    op_auipc   = 7'b0010111,
    op_jal     = 7'b1101111,
    op_jalr    = 7'b1100111,
    op_branch  = 7'b1100011,
    op_load    = 7'b0000011,
    op_store   = 7'b0100011,
    op_reg_imm = 7'b0010011,
    op_reg_reg = 7'b0110011,
    op_system  = 7'b1110011
  } opcode_e;

  // funct3 of register-immediate and register-register ops
  typedef enum logic [2:0] {
    f3_add     = 3'b000,  // add, sub, addi
    f3_sll     = 3'b001,
    f3_slt     = 3'b010,
    f3_sltu    = 3'b011,
    f3_xor     = 3'b100,
    f3_srl_sra = 3'b101,  // funct7 picks logical or arithmetic
    f3_or      = 3'b110,
    f3_and     = 3'b111
  } funct3_alu_e;

  // funct3 of conditional branches, 010 and 011 are reserved
  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } funct3_branch_e;

  localparam logic [2:0] funct3_mem_word = 3'b010;  // lw / sw

  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000;  // sub, sra, srai

  // r-type field layout, other formats reuse the same bit positions
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } insn_fields_t;

  localparam logic [31:0] ecall_word = 32'h0000_0073;

endpackage

/* rtl/rv_regfile.sv */
module rv_regfile (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   we,
  input  rv_core_pkg::reg_addr_t rd,
  input  rv_core_pkg::word_t     rd_data,
  input  rv_core_pkg::reg_addr_t rs1,
  output rv_core_pkg::word_t     rs1_data,
  input  rv_core_pkg::reg_addr_t rs2,
  output rv_core_pkg::word_t     rs2_data
);

  // x0 has no storage
  rv_core_pkg::word_t regs [1:rv_core_pkg::num_regs-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < rv_core_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin  // writes to x0 are dropped
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* rv_core.f */
rtl/rv_isa_pkg.sv
rtl/rv_core_pkg.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_core.sv
verification/rv_core_chk.sv
verification/rv_core_tb.sv

/* verification/rv_core_chk.sv */
module rv_core_chk (
  input logic                  clk,
  input logic                  rst,
  input rv_core_pkg::word_t    pc,
  input rv_core_pkg::word_t    dmem_addr,
  input rv_core_pkg::byte_we_t dmem_we,
  input logic                  halt
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0;  // summed into the testbench result

  // only whole-word stores exist
  we_whole_word: assert property (@(posedge clk) disable iff (rst)
    dmem_we == '0 || dmem_we == rv_core_pkg::store_we_word)
    else begin
      $error("dmem_we has a partial byte enable %b", dmem_we);
      fail_count++;
    end

  store_aligned: assert property (@(posedge clk) disable iff (rst)
    dmem_we != '0 |-> dmem_addr[1:0] == 2'b00)
    else begin
      $error("store to unaligned address %h", dmem_addr);
      fail_count++;
    end

  pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else begin
      $error("pc %h is not word aligned", pc);
      fail_count++;
    end

  // parked on ecall until reset
  halt_holds: assert property (@(posedge clk) disable iff (rst)
    halt |=> halt && $stable(pc) && dmem_we == '0)
    else begin
      $error("core left the halt state, pc %h", pc);
      fail_count++;
    end

endmodule

/* verification/rv_core_tb.sv */
module rv_core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int mem_words    = 256;
  localparam int halt_timeout = 200;  // cycles per program

  logic clk = 1'b0;
  logic rst = 1'b1;

  rv_core_pkg::word_t    pc;
  rv_core_pkg::word_t    insn;
  rv_core_pkg::word_t    dmem_addr;
  rv_core_pkg::word_t    dmem_rdata;
  rv_core_pkg::word_t    dmem_wdata;
  rv_core_pkg::byte_we_t dmem_we;
  logic                  halt;

  rv_core_pkg::word_t imem [mem_words];
  rv_core_pkg::word_t dmem [mem_words];

  rv_core_pkg::word_t rng;
  rv_core_pkg::word_t halt_addr;  // address of the ecall
  int unsigned        prog_len;
  int                 checks;
  int                 errors;
  int                 timeouts;

  always #4 clk = ~clk;

  rv_core i_rv_core (
    .clk        (clk),
    .rst        (rst),
    .pc         (pc),
    .insn       (insn),
    .dmem_addr  (dmem_addr),
    .dmem_rdata (dmem_rdata),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .halt       (halt)
  );

  bind rv_core rv_core_chk i_rv_core_chk (
    .clk       (clk),
    .rst       (rst),
    .pc        (pc),
    .dmem_addr (dmem_addr),
    .dmem_we   (dmem_we),
    .halt      (halt)
  );

  function automatic rv_core_pkg::word_t fill_word(int addr);
    return 32'hc0de_0000 + 32'(addr) * 32'h0001_0001;
  endfunction

  // word-addressed memories with combinational reads
  assign insn       = imem[pc[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < mem_words; i++) begin
        dmem[i] <= fill_word(i);  // known pattern every reset
      end
    end else if (dmem_we != '0) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
    end
  end

  function automatic rv_core_pkg::word_t next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic rv_core_pkg::word_t i_type(logic [11:0] imm, logic [4:0] rs1,
      logic [2:0] f3, logic [4:0] rd, rv_isa_pkg::opcode_e op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_core_pkg::word_t s_type(logic [11:0] imm, logic [4:0] rs2,
      logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, rv_isa_pkg::funct3_mem_word, imm[4:0], rv_isa_pkg::op_store};
  endfunction

  function automatic rv_core_pkg::word_t b_type(logic [12:0] off, logic [4:0] rs2,
      logic [4:0] rs1, rv_isa_pkg::funct3_branch_e cond);
    return {off[12], off[10:5], rs2, rs1, cond, off[4:1], off[11], rv_isa_pkg::op_branch};
  endfunction

  function automatic rv_core_pkg::word_t u_type(logic [19:0] upper, logic [4:0] rd,
      rv_isa_pkg::opcode_e op);
    return {upper, rd, op};
  endfunction

  function automatic rv_core_pkg::word_t j_type(logic [20:0] off, logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::op_jal};
  endfunction

  // reference models of the ISA operations
  function automatic rv_core_pkg::word_t model_alu(rv_isa_pkg::funct3_alu_e f3, logic alt,
      rv_core_pkg::word_t a, rv_core_pkg::word_t b);
    logic [4:0] sh;
    logic       lt_s;
    sh   = b[4:0];
    lt_s = (a[31] != b[31]) ? a[31] : (a < b);  // differing signs decide alone
    case (f3)
      rv_isa_pkg::f3_add:  return alt ? a - b : a + b;
      rv_isa_pkg::f3_sll:  return a << sh;
      rv_isa_pkg::f3_slt:  return {31'b0, lt_s};
      rv_isa_pkg::f3_sltu: return {31'b0, a < b};
      rv_isa_pkg::f3_xor:  return a ^ b;
      rv_isa_pkg::f3_or:   return a | b;
      rv_isa_pkg::f3_and:  return a & b;
      default:             return (a >> sh) | ((alt && a[31]) ? ~(32'hffff_ffff >> sh) : 32'h0);
    endcase
  endfunction

  function automatic logic branch_model(rv_isa_pkg::funct3_branch_e cond,
      rv_core_pkg::word_t a, rv_core_pkg::word_t b);
    logic lt_s;
    lt_s = (a[31] != b[31]) ? a[31] : (a < b);
    case (cond)
      rv_isa_pkg::br_beq:  return a == b;
      rv_isa_pkg::br_bne:  return a != b;
      rv_isa_pkg::br_blt:  return lt_s;
      rv_isa_pkg::br_bge:  return !lt_s;
      rv_isa_pkg::br_bltu: return a < b;
      default:             return a >= b;
    endcase
  endfunction

  task automatic check_word(string name, rv_core_pkg::word_t expected,
      rv_core_pkg::word_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR %s: expected %h, got %h", name, expected, actual);
    end
  endtask

  task automatic check_pc(rv_core_pkg::word_t expected, rv_core_pkg::word_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR pc: expected %h, got %h", expected, actual);
    end
  endtask

  task automatic check_halt(logic expected, logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR halt: expected %h, got %h", expected, actual);
    end
  endtask

  task automatic emit(rv_core_pkg::word_t w);
    imem[prog_len] = w;
    prog_len++;
  endtask

  function automatic rv_core_pkg::word_t here();
    return prog_len * 32'd4;
  endfunction

  task automatic load_const(logic [4:0] rd, rv_core_pkg::word_t value);
    rv_core_pkg::word_t upper;
    upper = value + 32'h800;  // addi adds a sign-extended low part
    emit(u_type(upper[31:12], rd, rv_isa_pkg::op_lui));
    emit(i_type(value[11:0], rd, rv_isa_pkg::f3_add, rd, rv_isa_pkg::op_reg_imm));
  endtask

  task automatic store_word(logic [4:0] rs2, int slot);
    emit(s_type(12'(slot * 4), rs2, 5'd0));
  endtask

  task automatic start_program();
    @(posedge clk);
    #1;
    rst = 1'b1;
    for (int i = 0; i < mem_words; i++) begin
      imem[i] = '0;  // opcode 0 decodes as a no-op
    end
    prog_len = 0;
  endtask

  task automatic end_program();
    halt_addr = here();
    emit(rv_isa_pkg::ecall_word);
  endtask

  task automatic run_program(output bit ok);
    int n;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    n   = 0;
    while (!halt && n < halt_timeout) begin
      @(posedge clk);
      #1;
      n++;
    end
    ok = halt;
    if (!halt) begin
      timeouts++;
      $display("program never halted within %0d cycles, pc is %h", halt_timeout, pc);
    end else begin
      check_pc(halt_addr, pc);
    end
  endtask

  // index 8 is sub and index 9 is sra
  task automatic test_alu(bit imm_form);
    rv_isa_pkg::funct3_alu_e f3;
    rv_core_pkg::word_t      a;
    rv_core_pkg::word_t      b;
    rv_core_pkg::word_t      expected [10];
    logic [11:0]             imm;
    logic [6:0]              f7;
    logic                    alt;
    bit                      ok;
    start_program();
    for (int i = 0; i < 10; i++) begin
      f3  = rv_isa_pkg::funct3_alu_e'(i < 8 ? i : (i == 8 ? 0 : 5));
      alt = i >= 8;
      f7  = alt ? rv_isa_pkg::funct7_alt : rv_isa_pkg::funct7_base;
      a   = next_rand();
      b   = next_rand() | 32'h0000_0020;  // shift amounts above 31
      if (i % 2 == 1) a[31] = 1'b1;
      if (imm_form && i == 8) begin
        expected[i] = fill_word(i);  // there is no subi
      end else begin
        load_const(5'd1, a);
        if (imm_form) begin
          imm = b[11:0];
          if (f3 inside {rv_isa_pkg::f3_sll, rv_isa_pkg::f3_srl_sra}) imm = {f7, b[4:0]};
          b = {{20{imm[11]}}, imm};
          emit(i_type(imm, 5'd1, f3, 5'd2, rv_isa_pkg::op_reg_imm));
        end else begin
          load_const(5'd3, b);
          emit({f7, 5'd3, 5'd1, f3, 5'd2, rv_isa_pkg::op_reg_reg});
        end
        store_word(5'd2, i);
        expected[i] = model_alu(f3, alt, a, b);
      end
    end
    end_program();
    run_program(ok);
    if (ok) begin
      for (int i = 0; i < 10; i++) begin
        check_word($sformatf("dmem[%0d] alu case %0d imm %0d", i, i, imm_form),
                   expected[i], dmem[i]);
      end
    end
  endtask

  task automatic test_branches();
    rv_isa_pkg::funct3_branch_e conds [6];
    rv_core_pkg::word_t         expected [12];
    rv_core_pkg::word_t         neg;
    rv_core_pkg::word_t         pos;
    rv_core_pkg::word_t         a;
    rv_core_pkg::word_t         b;
    int                         slot;
    bit                         ok;
    conds = '{rv_isa_pkg::br_beq, rv_isa_pkg::br_bne, rv_isa_pkg::br_blt,
              rv_isa_pkg::br_bge, rv_isa_pkg::br_bltu, rv_isa_pkg::br_bgeu};
    start_program();
    for (int c = 0; c < 6; c++) begin
      for (int p = 0; p < 2; p++) begin
        neg  = next_rand() | 32'h8000_0000;
        pos  = next_rand() & 32'h7fff_ffff;
        slot = c * 2 + p;
        if (conds[c] inside {rv_isa_pkg::br_beq, rv_isa_pkg::br_bne}) begin
          a = pos;
          b = (p == 0) ? pos : pos + 1;
        end else begin
          a = (p == 0) ? neg : pos;  // swapping flips the outcome
          b = (p == 0) ? pos : neg;
        end
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit(b_type(13'd16, 5'd2, 5'd1, conds[c]));
        emit(i_type(12'h111, 5'd0, rv_isa_pkg::f3_add, 5'd5, rv_isa_pkg::op_reg_imm));
        store_word(5'd5, slot);
        emit(j_type(21'd12, 5'd0));  // skip the taken path
        emit(i_type(12'h222, 5'd0, rv_isa_pkg::f3_add, 5'd5, rv_isa_pkg::op_reg_imm));
        store_word(5'd5, slot);
        expected[slot] = branch_model(conds[c], a, b) ? 32'h222 : 32'h111;
      end
    end
    end_program();
    run_program(ok);
    if (ok) begin
      for (int s = 0; s < 12; s++) begin
        check_word($sformatf("dmem[%0d] %s", s, conds[s / 2].name()), expected[s], dmem[s]);
      end
    end
  endtask

  task automatic test_jumps();
    rv_core_pkg::word_t jal_pc;
    rv_core_pkg::word_t jalr_pc;
    rv_core_pkg::word_t auipc_pc;
    rv_core_pkg::word_t target;
    rv_core_pkg::word_t base;
    rv_core_pkg::word_t r;
    bit                 ok;
    r = next_rand();
    start_program();
    jal_pc = here();
    emit(j_type(21'd12, 5'd1));
    emit(i_type(12'h333, 5'd0, rv_isa_pkg::f3_add, 5'd5, rv_isa_pkg::op_reg_imm));
    store_word(5'd5, 1);  // wrong path
    target = here() + 32'd16;
    base   = target - 32'd3;  // odd sum so jalr must clear bit 0
    emit(i_type(base[11:0], 5'd0, rv_isa_pkg::f3_add, 5'd7, rv_isa_pkg::op_reg_imm));
    jalr_pc = here();
    emit(i_type(12'd4, 5'd7, 3'b000, 5'd2, rv_isa_pkg::op_jalr));
    emit(i_type(12'h444, 5'd0, rv_isa_pkg::f3_add, 5'd5, rv_isa_pkg::op_reg_imm));
    store_word(5'd5, 2);  // wrong path
    auipc_pc = here();
    emit(u_type(r[19:0], 5'd6, rv_isa_pkg::op_auipc));
    store_word(5'd1, 3);
    store_word(5'd2, 4);
    store_word(5'd6, 5);
    end_program();
    run_program(ok);
    if (ok) begin
      check_word("dmem[1] after jal", fill_word(1), dmem[1]);
      check_word("dmem[2] after jalr", fill_word(2), dmem[2]);
      check_word("jal link", jal_pc + 32'd4, dmem[3]);
      check_word("jalr link", jalr_pc + 32'd4, dmem[4]);
      check_word("auipc result", auipc_pc + {r[19:0], 12'h000}, dmem[5]);
    end
  endtask

  task automatic test_load_store();
    rv_core_pkg::word_t value;
    bit                 ok;
    value = next_rand();
    start_program();
    load_const(5'd1, value);
    store_word(5'd1, 10);
    emit(i_type(12'd32, 5'd0, rv_isa_pkg::f3_add, 5'd4, rv_isa_pkg::op_reg_imm));
    emit(i_type(12'd8, 5'd4, rv_isa_pkg::funct3_mem_word, 5'd3, rv_isa_pkg::op_load));
    store_word(5'd3, 11);
    emit(i_type(12'h5a5, 5'd1, rv_isa_pkg::f3_add, 5'd0, rv_isa_pkg::op_reg_imm));  // x0 write
    store_word(5'd0, 12);
    end_program();
    run_program(ok);
    if (ok) begin
      check_word("dmem[10] stored word", value, dmem[10]);
      check_word("dmem[11] loaded word", value, dmem[11]);
      check_word("dmem[12] x0", 32'h0, dmem[12]);
    end
  endtask

  task automatic test_halt();
    rv_core_pkg::word_t snapshot [mem_words];
    bit                 ok;
    start_program();
    emit(i_type(12'h0a5, 5'd0, rv_isa_pkg::f3_add, 5'd1, rv_isa_pkg::op_reg_imm));
    store_word(5'd1, 20);
    end_program();
    store_word(5'd1, 21);  // past the ecall and never executed
    run_program(ok);
    if (ok) begin
      for (int i = 0; i < mem_words; i++) begin
        snapshot[i] = dmem[i];
      end
      repeat (10) begin
        @(posedge clk);
        #1;
        check_pc(halt_addr, pc);
        check_halt(1'b1, halt);
      end
      for (int i = 0; i < mem_words; i++) begin
        check_word($sformatf("dmem[%0d] while halted", i), snapshot[i], dmem[i]);
      end
      check_word("dmem[20] before ecall", 32'h0a5, dmem[20]);
      check_word("dmem[21] after ecall", fill_word(21), dmem[21]);
    end
  endtask

  initial begin
    rng       = 32'd58797;
    checks    = 0;
    errors    = 0;
    timeouts  = 0;
    prog_len  = 0;
    halt_addr = '0;
    for (int i = 0; i < mem_words; i++) begin
      imem[i] = '0;
    end
    test_alu(1'b1);
    test_alu(1'b0);
    test_branches();
    test_jumps();
    test_load_store();
    test_halt();
    $display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
             checks, errors, i_rv_core.i_rv_core_chk.fail_count, timeouts);
    if (errors == 0 && timeouts == 0 && i_rv_core.i_rv_core_chk.fail_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
